// ==== verilog/fetch_pkg.sv ====
package fetch_pkg;

	// First instruction fetched after reset
	localparam logic [31:0] reset_vector = 32'h0000_0100;

	// Default number of cache lines, one word per line
	localparam int icache_lines = 16;

	// Width of an integer register index
	localparam int reg_index_w = 5;

	// Full encodings of the system words that stall fetch
	localparam logic [31:0] ecall_word = 32'h0000_0073;
	localparam logic [31:0] wfi_word = 32'h1050_0073;
	localparam logic [31:0] mret_word = 32'h3020_0073;

	// RV32I major opcodes, bits [6:0] of the instruction
	typedef enum logic [6:0] {
		opc_load = 7'b0000011,
		opc_store = 7'b0100011,
		opc_branch = 7'b1100011,
		opc_jal = 7'b1101111,
		opc_jalr = 7'b1100111,
		opc_op_imm = 7'b0010011,
		opc_op = 7'b0110011,
		opc_lui = 7'b0110111,
		opc_auipc = 7'b0010111,
		opc_system = 7'b1110011,
		opc_misc_mem = 7'b0001111
	} opcode_t;

	// Control-flow class of a fetched word
	typedef enum logic [1:0] {
		// Fetch simply continues at pc + 4
		class_sequential = 2'd0,
		// Branch, jal, jalr and mret wait for the jump target
		class_wait_jump = 2'd1,
		// Ecall and wfi wait for an interrupt
		class_wait_irq = 2'd2
	} inst_class_t;

	// Fetch FSM states
	typedef enum logic [1:0] {
		state_wait_icache = 2'd0,
		state_wait_jump = 2'd1,
		state_wait_irq = 2'd2
	} fetch_state_t;

endpackage

// ==== verilog/icache.sv ====
`timescale 1ns/1ps

module icache #(
	parameter int lines = fetch_pkg::icache_lines
)(
	input logic i_clock,
	input logic i_reset,

	// Lookup
	input logic [31:0] i_pc,
	output logic [31:0] o_rdata,
	output logic o_ready,

	// Refill bus
	output logic o_bus_request,
	output logic [31:0] o_bus_address,
	input logic i_bus_ready,
	input logic [31:0] i_bus_rdata,

	// Statistics
	output logic [31:0] o_hit_count,
	output logic [31:0] o_miss_count
);

	localparam int index_w = $clog2(lines);
	localparam int tag_w = 30 - index_w;

	// Line storage
	logic [lines-1:0] valid;
	logic [tag_w-1:0] tag_array [lines];
	logic [31:0] data_array [lines];

	// Refill in flight and the word address it was started for
	logic refilling;
	logic [31:0] refill_address;

	logic [index_w-1:0] pc_index;
	logic [tag_w-1:0] pc_tag;
	logic [index_w-1:0] refill_index;
	logic [tag_w-1:0] refill_tag;
	logic start_refill;

	assign pc_index = i_pc[2 +: index_w];
	assign pc_tag = i_pc[31:2+index_w];
	assign refill_index = refill_address[2 +: index_w];
	assign refill_tag = refill_address[31:2+index_w];

	// Combinational lookup
	assign o_ready = valid[pc_index] && (tag_array[pc_index] == pc_tag);
	assign o_rdata = data_array[pc_index];

	// A new refill only starts once the previous one has returned
	assign start_refill = !o_ready && !refilling;

	assign o_bus_request = refilling;
	assign o_bus_address = refill_address;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			refilling <= 1'b0;
			valid <= '0;
			o_hit_count <= '0;
			o_miss_count <= '0;
		end
		else begin
			if (o_ready) begin
				o_hit_count <= o_hit_count + 32'd1;
			end

			if (refilling) begin
				// Hold request and address until the bus answers
				if (i_bus_ready) begin
					refilling <= 1'b0;
					valid[refill_index] <= 1'b1;
				end
			end
			else if (start_refill) begin
				refilling <= 1'b1;
				o_miss_count <= o_miss_count + 32'd1;
			end
		end
	end

	// Miss address is latched so a moving pc does not disturb the refill
	always_ff @(posedge i_clock) begin
		if (start_refill) begin
			refill_address <= {i_pc[31:2], 2'b00};
		end
	end

	// Tag and data written with the returning bus word
	always_ff @(posedge i_clock) begin
		if (refilling && i_bus_ready) begin
			tag_array[refill_index] <= refill_tag;
			data_array[refill_index] <= i_bus_rdata;
		end
	end

endmodule

// ==== verilog/fetch_predecode.sv ====
`timescale 1ns/1ps

module fetch_predecode (
	input logic [31:0] i_instruction,
	output logic [fetch_pkg::reg_index_w-1:0] o_rs1,
	output logic [fetch_pkg::reg_index_w-1:0] o_rs2,
	output logic [fetch_pkg::reg_index_w-1:0] o_rd,
	output fetch_pkg::inst_class_t o_class
);

	import fetch_pkg::*;

	// Encoding formats; fmt_none carries no register fields
	typedef enum logic [2:0] {
		fmt_r,
		fmt_i,
		fmt_s,
		fmt_b,
		fmt_u,
		fmt_j,
		fmt_none
	} format_t;

	opcode_t opcode;
	format_t format;
	logic [2:0] funct3;
	logic use_rs1;
	logic use_rs2;
	logic use_rd;

	assign opcode = opcode_t'(i_instruction[6:0]);
	assign funct3 = i_instruction[14:12];

	always_comb begin
		case (opcode)
			opc_load, opc_jalr, opc_op_imm: format = fmt_i;
			opc_store: format = fmt_s;
			opc_branch: format = fmt_b;
			opc_jal: format = fmt_j;
			opc_op: format = fmt_r;
			opc_lui, opc_auipc: format = fmt_u;
			// CSR accesses behave like I-type, ecall/wfi/mret use nothing
			opc_system: format = (funct3 != 3'b000) ? fmt_i : fmt_none;
			default: format = fmt_none;
		endcase
	end

	assign use_rs1 = format inside {fmt_r, fmt_i, fmt_s, fmt_b};
	assign use_rs2 = format inside {fmt_r, fmt_s, fmt_b};
	assign use_rd = format inside {fmt_r, fmt_i, fmt_u, fmt_j};

	// Unused fields read as x0
	assign o_rs1 = use_rs1 ? i_instruction[19:15] : '0;
	assign o_rs2 = use_rs2 ? i_instruction[24:20] : '0;
	assign o_rd = use_rd ? i_instruction[11:7] : '0;

	always_comb begin
		case (opcode)
			opc_branch, opc_jal, opc_jalr: o_class = class_wait_jump;
			opc_system: begin
				if (i_instruction == mret_word) begin
					o_class = class_wait_jump;
				end
				else if (i_instruction == ecall_word || i_instruction == wfi_word) begin
					o_class = class_wait_irq;
				end
				else begin
					o_class = class_sequential;
				end
			end
			default: o_class = class_sequential;
		endcase
	end

endmodule

// ==== verilog/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
	input logic i_clock,
	input logic i_reset,

	// Jump target from the pipeline
	input logic i_jump,
	input logic [31:0] i_jump_pc,

	// Interrupt
	input logic i_irq_pending,
	input logic [31:0] i_irq_pc,
	output logic o_irq_dispatched,
	output logic [31:0] o_irq_epc,

	// Cache lookup
	output logic [31:0] o_pc,
	input logic [31:0] i_cache_rdata,
	input logic i_cache_ready,

	// Predecode results for the word at o_pc
	input logic [fetch_pkg::reg_index_w-1:0] i_rs1,
	input logic [fetch_pkg::reg_index_w-1:0] i_rs2,
	input logic [fetch_pkg::reg_index_w-1:0] i_rd,
	input fetch_pkg::inst_class_t i_class,

	// Pipeline output
	input logic i_busy,
	output logic o_data_strobe,
	output logic [31:0] o_data_pc,
	output logic [31:0] o_data_instruction,
	output logic [fetch_pkg::reg_index_w-1:0] o_data_rs1,
	output logic [fetch_pkg::reg_index_w-1:0] o_data_rs2,
	output logic [fetch_pkg::reg_index_w-1:0] o_data_rd
);

	import fetch_pkg::*;

	fetch_state_t state;
	logic [31:0] pc;
	logic irq_pending_r;

	logic irq_sampled;
	logic dispatch;
	logic deliver;

	assign o_pc = pc;

	// Pending line only watched while fetching or parked on ecall/wfi
	assign irq_sampled = (state == state_wait_icache) || (state == state_wait_irq);
	assign dispatch = irq_sampled && i_irq_pending && !irq_pending_r;

	// Interrupt wins over a delivery in the same cycle
	assign deliver = (state == state_wait_icache) && !dispatch && i_cache_ready && !i_busy;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= state_wait_icache;
			pc <= reset_vector;
			irq_pending_r <= 1'b0;
			o_irq_dispatched <= 1'b0;
			o_data_strobe <= 1'b0;
		end
		else begin
			o_irq_dispatched <= dispatch;

			if (irq_sampled) begin
				irq_pending_r <= i_irq_pending;
			end

			case (state)
				state_wait_icache: begin
					if (dispatch) begin
						pc <= i_irq_pc;
					end
					else if (deliver) begin
						o_data_strobe <= ~o_data_strobe;
						pc <= pc + 32'd4;

						// Control flow parks fetch until the pipeline resolves it
						if (i_class == class_wait_jump) begin
							state <= state_wait_jump;
						end
						else if (i_class == class_wait_irq) begin
							state <= state_wait_irq;
						end
					end
				end

				state_wait_jump: begin
					if (i_jump) begin
						pc <= i_jump_pc;
						state <= state_wait_icache;
					end
				end

				state_wait_irq: begin
					if (dispatch) begin
						pc <= i_irq_pc;
						state <= state_wait_icache;
					end
				end

				default: begin
					state <= state_wait_icache;
				end
			endcase
		end
	end

	// Payload registers follow the strobe and dispatch events
	always_ff @(posedge i_clock) begin
		if (dispatch) begin
			// Return address is the first word not yet delivered
			o_irq_epc <= pc;
		end

		if (deliver) begin
			o_data_pc <= pc;
			o_data_instruction <= i_cache_rdata;
			o_data_rs1 <= i_rs1;
			o_data_rs2 <= i_rs2;
			o_data_rd <= i_rd;
		end
	end

endmodule

// ==== verilog/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top (
	input logic i_clock,
	input logic i_reset,

	// Control
	input logic i_jump,
	input logic [31:0] i_jump_pc,

	// Interrupt
	input logic i_irq_pending,
	input logic [31:0] i_irq_pc,
	output logic o_irq_dispatched,
	output logic [31:0] o_irq_epc,

	// Memory bus
	output logic o_bus_request,
	output logic [31:0] o_bus_address,
	input logic i_bus_ready,
	input logic [31:0] i_bus_rdata,

	// Pipeline output
	input logic i_busy,
	output logic o_data_strobe,
	output logic [31:0] o_data_pc,
	output logic [31:0] o_data_instruction,
	output logic [fetch_pkg::reg_index_w-1:0] o_data_rs1,
	output logic [fetch_pkg::reg_index_w-1:0] o_data_rs2,
	output logic [fetch_pkg::reg_index_w-1:0] o_data_rd,

	// Cache statistics
	output logic [31:0] o_hit_count,
	output logic [31:0] o_miss_count
);

	import fetch_pkg::*;

	logic [31:0] pc;
	logic [31:0] cache_rdata;
	logic cache_ready;
	logic [reg_index_w-1:0] rs1;
	logic [reg_index_w-1:0] rs2;
	logic [reg_index_w-1:0] rd;
	inst_class_t inst_class;

	icache #(
		.lines(icache_lines)
	) u_icache (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_pc(pc),
		.o_rdata(cache_rdata),
		.o_ready(cache_ready),
		.o_bus_request(o_bus_request),
		.o_bus_address(o_bus_address),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata),
		.o_hit_count(o_hit_count),
		.o_miss_count(o_miss_count)
	);

	// Decodes the word currently presented by the cache
	fetch_predecode u_predecode (
		.i_instruction(cache_rdata),
		.o_rs1(rs1),
		.o_rs2(rs2),
		.o_rd(rd),
		.o_class(inst_class)
	);

	fetch_unit u_fetch (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_jump(i_jump),
		.i_jump_pc(i_jump_pc),
		.i_irq_pending(i_irq_pending),
		.i_irq_pc(i_irq_pc),
		.o_irq_dispatched(o_irq_dispatched),
		.o_irq_epc(o_irq_epc),
		.o_pc(pc),
		.i_cache_rdata(cache_rdata),
		.i_cache_ready(cache_ready),
		.i_rs1(rs1),
		.i_rs2(rs2),
		.i_rd(rd),
		.i_class(inst_class),
		.i_busy(i_busy),
		.o_data_strobe(o_data_strobe),
		.o_data_pc(o_data_pc),
		.o_data_instruction(o_data_instruction),
		.o_data_rs1(o_data_rs1),
		.o_data_rs2(o_data_rs2),
		.o_data_rd(o_data_rd)
	);

endmodule

// ==== test/fetch_tb.sv ====
`timescale 1ns/1ps

module fetch_tb;

	localparam string pattern_file = "test/fetch_patterns.mem";

	// Fixed offsets of the sections in the pattern file
	localparam int image_base = 'h00;
	localparam int jump_base = 'h40;
	localparam int vector_base = 'h48;
	localparam int mid_irq_base = 'h4c;
	localparam int expect_base = 'h50;

	logic i_clock;
	logic i_reset;
	logic i_jump;
	logic [31:0] i_jump_pc;
	logic i_irq_pending;
	logic [31:0] i_irq_pc;
	logic o_irq_dispatched;
	logic [31:0] o_irq_epc;
	logic o_bus_request;
	logic [31:0] o_bus_address;
	logic i_bus_ready;
	logic [31:0] i_bus_rdata;
	logic i_busy;
	logic o_data_strobe;
	logic [31:0] o_data_pc;
	logic [31:0] o_data_instruction;
	logic [4:0] o_data_rs1;
	logic [4:0] o_data_rs2;
	logic [4:0] o_data_rd;
	logic [31:0] o_hit_count;
	logic [31:0] o_miss_count;

	logic [31:0] pat [0:127];
	logic [31:0] image [logic [31:0]];
	logic patterns_loaded;
	integer seed;
	int bus_delay;
	int expect_count;
	int delivered;
	int jump_index;
	int vector_index;
	int dispatches;
	int model_misses;
	logic last_strobe;
	logic irq_hold;
	logic [31:0] expected_epc;
	logic [31:0] parked_hits;
	logic [15:0] model_valid;
	logic [25:0] model_tag [16];

	fetch_top i_dut (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_jump(i_jump),
		.i_jump_pc(i_jump_pc),
		.i_irq_pending(i_irq_pending),
		.i_irq_pc(i_irq_pc),
		.o_irq_dispatched(o_irq_dispatched),
		.o_irq_epc(o_irq_epc),
		.o_bus_request(o_bus_request),
		.o_bus_address(o_bus_address),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata),
		.i_busy(i_busy),
		.o_data_strobe(o_data_strobe),
		.o_data_pc(o_data_pc),
		.o_data_instruction(o_data_instruction),
		.o_data_rs1(o_data_rs1),
		.o_data_rs2(o_data_rs2),
		.o_data_rd(o_data_rd),
		.o_hit_count(o_hit_count),
		.o_miss_count(o_miss_count)
	);

	always #4 i_clock = ~i_clock;

	task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
			$display("SOME TESTS FAILED");
			$fatal(1, "check failed");
		end
	endtask

	// Words outside the image get a fill that depends on every address bit
	function automatic logic [31:0] memory_word(input logic [31:0] address);
		if (image.exists(address)) begin
			return image[address];
		end
		return {address[31:7] ^ address[24:0], 7'b0010011};
	endfunction

	// Register fields and control class per the RV32I formats
	task automatic decode_reference(input logic [31:0] w, output logic [4:0] rs1,
			output logic [4:0] rs2, output logic [4:0] rd, output int cls);
		logic use1;
		logic use2;
		logic used;
		use1 = 1'b0;
		use2 = 1'b0;
		used = 1'b0;
		cls = 0;
		case (w[6:0])
			7'h33: {use1, use2, used} = 3'b111;
			7'h13, 7'h03: {use1, used} = 2'b11;
			7'h67: begin
				{use1, used} = 2'b11;
				cls = 1;
			end
			7'h23: {use1, use2} = 2'b11;
			7'h63: begin
				{use1, use2} = 2'b11;
				cls = 1;
			end
			7'h37, 7'h17: used = 1'b1;
			7'h6f: begin
				used = 1'b1;
				cls = 1;
			end
			7'h73: begin
				if (w[14:12] != 3'b000) begin
					{use1, used} = 2'b11;
				end
				else if (w == 32'h3020_0073) begin
					cls = 1;
				end
				else if (w == 32'h0000_0073 || w == 32'h1050_0073) begin
					cls = 2;
				end
			end
			default: cls = 0;
		endcase
		rs1 = use1 ? w[19:15] : 5'd0;
		rs2 = use2 ? w[24:20] : 5'd0;
		rd = used ? w[11:7] : 5'd0;
	endtask

	// Direct-mapped model: 16 lines indexed by pc[5:2]
	task automatic touch_line(input logic [31:0] address);
		if (!model_valid[address[5:2]] || model_tag[address[5:2]] != address[31:6]) begin
			model_misses = model_misses + 1;
			model_valid[address[5:2]] = 1'b1;
			model_tag[address[5:2]] = address[31:6];
		end
	endtask

	task automatic handle_delivery();
		logic [31:0] pc_expected;
		logic [31:0] word;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [4:0] rd;
		int cls;
		if (irq_hold) begin
			i_irq_pending = 1'b0;
			irq_hold = 1'b0;
		end
		pc_expected = pat[expect_base + 1 + delivered];
		word = memory_word(pc_expected);
		decode_reference(word, rs1, rs2, rd, cls);
		check_equal(o_data_pc, pc_expected, "delivered pc");
		check_equal(o_data_instruction, word, "instruction");
		check_equal(32'(o_data_rs1), 32'(rs1), "rs1");
		check_equal(32'(o_data_rs2), 32'(rs2), "rs2");
		check_equal(32'(o_data_rd), 32'(rd), "rd");
		touch_line(pc_expected);
		delivered = delivered + 1;
		if (cls == 1) begin
			// The stalled pc + 4 is still looked up before the jump lands
			touch_line(pc_expected + 32'd4);
			i_jump = 1'b1;
			i_jump_pc = pat[jump_base + 1 + jump_index];
			jump_index = jump_index + 1;
		end
		else if (cls == 2) begin
			touch_line(pc_expected + 32'd4);
			if (vector_index < int'(pat[vector_base])) begin
				i_irq_pc = pat[vector_base + 1 + vector_index];
				i_irq_pending = 1'b1;
				irq_hold = 1'b1;
				expected_epc = pc_expected + 32'd4;
				vector_index = vector_index + 1;
			end
		end
		else if (delivered == int'(pat[mid_irq_base])) begin
			touch_line(pc_expected + 32'd4);
			i_irq_pc = pat[mid_irq_base + 1];
			i_irq_pending = 1'b1;
			irq_hold = 1'b1;
			expected_epc = pc_expected + 32'd4;
		end
	endtask

	// Bus memory and busy share one random stream
	always @(posedge i_clock) begin
		#1;
		i_bus_ready = 1'b0;
		i_busy = ($random(seed) & 3) == 0;
		if (o_bus_request) begin
			if (bus_delay == 0) begin
				i_bus_ready = 1'b1;
				i_bus_rdata = memory_word(o_bus_address);
				bus_delay = int'($unsigned($random(seed)) % 4);
			end
			else begin
				bus_delay = bus_delay - 1;
			end
		end
	end

	initial begin
		wait (patterns_loaded);
		repeat (expect_count * 200) @(posedge i_clock);
		$display("Timeout: the fetch stream did not complete in time");
		$display("SOME TESTS FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin
		i_clock = 1'b0;
		i_reset = 1'b1;
		i_jump = 1'b0;
		i_jump_pc = '0;
		i_irq_pending = 1'b0;
		i_irq_pc = '0;
		i_bus_ready = 1'b0;
		i_bus_rdata = '0;
		i_busy = 1'b0;
		seed = 32'h6c9ef05c;
		bus_delay = 0;
		delivered = 0;
		jump_index = 0;
		vector_index = 0;
		dispatches = 0;
		model_misses = 0;
		model_valid = '0;
		irq_hold = 1'b0;
		expected_epc = '0;
		parked_hits = '0;
		patterns_loaded = 1'b0;

		$readmemh(pattern_file, pat);
		for (int i = 0; i < int'(pat[image_base]); i++) begin
			image[pat[image_base + 1 + 2 * i]] = pat[image_base + 2 + 2 * i];
		end
		expect_count = int'(pat[expect_base]);
		patterns_loaded = 1'b1;

		repeat (16) @(posedge i_clock);
		#1;
		i_reset = 1'b0;
		last_strobe = o_data_strobe;

		while (delivered < expect_count) begin
			@(posedge i_clock);
			#1;
			i_jump = 1'b0;
			if (o_irq_dispatched) begin
				dispatches = dispatches + 1;
				check_equal(o_irq_epc, expected_epc, "interrupt epc");
			end
			if (o_data_strobe != last_strobe) begin
				last_strobe = o_data_strobe;
				handle_delivery();
			end
		end

		// Let the refill of the parked pc finish
		repeat (2) @(posedge i_clock);
		#1;
		while (o_bus_request) begin
			@(posedge i_clock);
			#1;
		end

		// Parked pc now hits in every cycle
		parked_hits = o_hit_count;
		repeat (4) @(posedge i_clock);
		#1;
		check_equal(32'(o_data_strobe), 32'(last_strobe), "no delivery after the final wfi");
		check_equal(o_hit_count, parked_hits + 32'd4, "hits while parked on the final wfi");
		check_equal(dispatches, int'(pat[vector_base]) + 1, "interrupt dispatch count");
		check_equal(o_miss_count, model_misses, "miss count");
		check_equal(32'(o_hit_count >= delivered), 32'd1, "hit count covers deliveries");
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

// ==== test/fetch_patterns.mem ====
// Image section at 0x00: word count, then address and instruction word pairs
@00
00000010
00000100 00500093
00000104 12345137
00000108 002081B3
0000010C 00312423
00000110 00208863
00000120 00001217
00000124 00022283
00000128 0FF2E313
0000012C 00737433
00000130 00000073
00000138 30051473
0000013C 00008067
00000144 10500073
00000200 00100393
00000204 000000EF
00000240 30200073
// Jump targets at 0x40: count, then one target per wait_jump
@40
00000004
00000120
0000012C
00000138
00000144
// Interrupt vectors at 0x48: count, then one vector per wait_irq
@48
00000001
00000240
// Mid-stream interrupt at 0x4c: delivery count, then vector
@4C
00000008
00000200
// Expected pc stream at 0x50: count, then the pc of each delivery
@50
00000010
00000100
00000104
00000108
0000010C
00000110
00000120
00000124
00000128
00000200
00000204
0000012C
00000130
00000240
00000138
0000013C
00000144

// ==== sim.f ====
verilog/fetch_pkg.sv
verilog/icache.sv
verilog/fetch_predecode.sv
verilog/fetch_unit.sv
verilog/fetch_top.sv
test/fetch_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS = --binary --timing -j 0
TOP = fetch_tb
FILELIST = sim.f
OBJDIR = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --Mdir $(OBJDIR) --top-module $(TOP) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
